// ==== tb.f ====
+incdir+include
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_link_top.sv
tests/uart_link_chk.sv
tests/uart_link_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f tb.f --top-module uart_link_tb -o uart_link_sim || exit 1
out="$(./obj_dir/uart_link_sim +verilator+error+limit+100 2>&1)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/uart_link_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_link_tb;

	// Short strobe period keeps frames fast
	localparam int BAUD_DIV   = 4;
	localparam int N_LOOP     = 20;
	// Loopback bytes, busy request, framing error, frame after glitch
	localparam int N_FRAMES   = N_LOOP + 3;
	localparam int BIT_CLKS   = `UART_OVERSAMPLE * BAUD_DIV;
	localparam int FRAME_CLKS = BIT_CLKS * (`UART_DATA_BITS + 2);
	localparam int WDOG_NS    = (N_FRAMES + 4) * FRAME_CLKS * 10;

	logic                       clk;
	logic                       arst_n;
	logic                       tx_start;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic                       txd;
	logic                       tx_done;
	logic                       rxd;
	logic                       rx_valid;
	logic [`UART_DATA_BITS-1:0] rx_data;
	logic                       rx_frame_err;
	// Line fault and expectations
	logic                       force_low;
	logic                       expect_err;
	logic                       quiet;
	logic [15:0]                lfsr;

	initial clk = 1'b0;
	always #5 clk = ~clk;

	uart_link_top #(
		.BAUD_DIV (BAUD_DIV)
	) i_dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.txd          (txd),
		.tx_done      (tx_done),
		.rxd          (rxd),
		.rx_valid     (rx_valid),
		.rx_data      (rx_data),
		.rx_frame_err (rx_frame_err)
	);

	// Loopback, pulled low by fault injection
	assign rxd = txd && !force_low;

	bind uart_link_top uart_link_chk #(
		.BAUD_DIV (BAUD_DIV)
	) i_chk (
		.clk      (clk),
		.arst_n   (arst_n),
		.s_tick   (s_tick),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.txd      (txd),
		.tx_done  (tx_done),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at first error");
	endtask

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// One LFSR step per bit
	task automatic draw_byte(output logic [`UART_DATA_BITS-1:0] b);
		for (int i = 0; i < `UART_DATA_BITS; i++)
		begin
			b[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Hold the request until tx_done drops
	task automatic start_frame(input logic [`UART_DATA_BITS-1:0] b);
		tx_data  = b;
		tx_start = 1'b1;
		while (tx_done)
		begin
			@(posedge clk);
			#1;
		end
		tx_start = 1'b0;
	endtask

	task automatic wait_rx();
		@(posedge clk);
		#1;
		while (!rx_valid)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic wait_idle();
		while (!tx_done)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	//////////////////////////////////////////////////
	// Checks tied to line faults
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!arst_n)
		rx_valid |-> (rx_frame_err == expect_err))
	else
		stop_on_failure($sformatf("FAILED framing check: expected %0b, actual %0b",
			$sampled(expect_err), $sampled(rx_frame_err)));

	// Nothing received between a glitch and the next real frame
	assert property (@(posedge clk) disable iff (!arst_n) !(quiet && rx_valid))
	else
		stop_on_failure("rx_valid pulsed after a start glitch on an idle line");

	// Poll the bound checker once per clock
	always @(negedge clk)
	begin
		if (i_dut.i_chk.fail_cnt != 0)
			stop_on_failure("A checker assertion on the top level ports failed");
	end

	initial
	begin
		#(WDOG_NS);
		stop_on_failure($sformatf("Timeout, the run did not finish within %0d ns", WDOG_NS));
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial
	begin
		logic [`UART_DATA_BITS-1:0] b;
		arst_n     = 1'b0;
		tx_start   = 1'b0;
		tx_data    = '0;
		force_low  = 1'b0;
		expect_err = 1'b0;
		quiet      = 1'b0;
		lfsr       = 16'd18777;
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Clean loopback
		for (int n = 0; n < N_LOOP; n++)
		begin
			draw_byte(b);
			start_frame(b);
			wait_rx();
			wait_idle();
		end

		// Other byte requested mid-frame, dropped before the frame ends
		draw_byte(b);
		start_frame(b);
		repeat (3 * BIT_CLKS) @(posedge clk);
		#1;
		tx_data  = ~b;
		tx_start = 1'b1;
		repeat (BIT_CLKS) @(posedge clk);
		#1;
		tx_start = 1'b0;
		wait_rx();
		wait_idle();

		// Line held low from the start of the stop bit
		draw_byte(b);
		start_frame(b);
		repeat (9 * BIT_CLKS) @(posedge clk);
		#1;
		force_low  = 1'b1;
		expect_err = 1'b1;
		wait_rx();
		force_low = 1'b0;
		@(posedge clk);
		#1;
		expect_err = 1'b0;
		wait_idle();

		// 3-strobe glitch on an idle line
		quiet     = 1'b1;
		force_low = 1'b1;
		repeat (3 * BAUD_DIV) @(posedge clk);
		#1;
		force_low = 1'b0;
		// Long enough for a false frame to reach its stop bit
		repeat (FRAME_CLKS) @(posedge clk);
		#1;
		draw_byte(b);
		start_frame(b);
		quiet = 1'b0;
		wait_rx();
		wait_idle();

		if (i_dut.i_chk.fail_cnt != 0)
			stop_on_failure("A checker assertion on the top level ports failed");
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tests/uart_link_chk.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_link_chk #(
	parameter int BAUD_DIV = `UART_BAUD_DIV
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       s_tick,
	input  logic                       tx_start,
	input  logic [`UART_DATA_BITS-1:0] tx_data,
	input  logic                       txd,
	input  logic                       tx_done,
	input  logic                       rx_valid,
	input  logic [`UART_DATA_BITS-1:0] rx_data
);

	// Start bit length in clocks, frame length in strobes
	localparam int START_CLKS    = `UART_OVERSAMPLE * BAUD_DIV;
	localparam int FRAME_STROBES = `UART_OVERSAMPLE * (`UART_DATA_BITS + 2);

	logic                       accept;
	logic [`UART_DATA_BITS-1:0] last_byte;
	// Clocks since acceptance, 0 when no start bit in flight
	int                         since_acc;
	int                         frame_strobes;
	int                         fail_cnt = 0;

	// Request taken on a strobe while the transmitter is done
	assign accept = s_tick && tx_start && tx_done;

	//////////////////////////////////////////////////
	// Reference copy of the accepted byte
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			last_byte     <= '0;
			since_acc     <= 0;
			frame_strobes <= 0;
		end
		else if (accept)
		begin
			last_byte     <= tx_data;
			since_acc     <= 1;
			frame_strobes <= 0;
		end
		else
		begin
			// One-shot window over the start bit and first data clock
			if (since_acc > START_CLKS)
				since_acc <= 0;
			else if (since_acc != 0)
				since_acc <= since_acc + 1;
			if (s_tick && !tx_done)
				frame_strobes <= frame_strobes + 1;
		end
	end

	//////////////////////////////////////////////////
	// Port assertions
	//////////////////////////////////////////////////

	// Idle line during reset and on the first clock after it
	assert property (@(posedge clk) $past(!arst_n) |-> (txd && tx_done && !rx_valid))
	else
	begin
		$error({"FAILED reset state: expected txd=1 tx_done=1 rx_valid=0, ",
			"actual txd=%b tx_done=%b rx_valid=%b"},
			$sampled(txd), $sampled(tx_done), $sampled(rx_valid));
		fail_cnt = fail_cnt + 1;
	end

	// Received byte is the last accepted one
	assert property (@(posedge clk) disable iff (!arst_n) rx_valid |-> (rx_data == last_byte))
	else
	begin
		$error("FAILED loopback data: expected %02h, actual %02h",
			$sampled(last_byte), $sampled(rx_data));
		fail_cnt = fail_cnt + 1;
	end

	// Start bit low for 16 strobes, one clk after acceptance
	assert property (@(posedge clk) disable iff (!arst_n)
		(since_acc >= 1 && since_acc <= START_CLKS) |-> !txd)
	else
	begin
		$error("FAILED frame shape start bit: expected txd 0, actual %b", $sampled(txd));
		fail_cnt = fail_cnt + 1;
	end

	// Then data bit 0 on the line
	assert property (@(posedge clk) disable iff (!arst_n)
		(since_acc == START_CLKS + 1) |-> (txd == last_byte[0]))
	else
	begin
		$error("FAILED frame shape bit 0: expected %b, actual %b",
			$sampled(last_byte[0]), $sampled(txd));
		fail_cnt = fail_cnt + 1;
	end

	// tx_done back high only after the whole frame
	assert property (@(posedge clk) disable iff (!arst_n)
		$rose(tx_done) |-> (frame_strobes == FRAME_STROBES))
	else
	begin
		$error("FAILED frame length: expected %0d strobes, actual %0d",
			FRAME_STROBES, $sampled(frame_strobes));
		fail_cnt = fail_cnt + 1;
	end

endmodule

`default_nettype wire

// ==== hw/uart_link_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_link_top
	import uart_pkg::*;
#(
	parameter int BAUD_DIV = `UART_BAUD_DIV
) (
	input  logic                       clk,
	input  logic                       arst_n,
	// Transmit side
	input  logic                       tx_start,
	input  logic [`UART_DATA_BITS-1:0] tx_data,
	output logic                       txd,
	output logic                       tx_done,
	// Receive side
	input  logic                       rxd,
	output logic                       rx_valid,
	output logic [`UART_DATA_BITS-1:0] rx_data,
	output logic                       rx_frame_err
);

	logic       s_tick;
	tx_req_t    tx_req;
	rx_result_t rx_res;

	// Request and result structs
	assign tx_req.start = tx_start;
	assign tx_req.data  = tx_data;
	assign rx_data      = rx_res.data;
	assign rx_frame_err = rx_res.frame_err;

	//////////////////////////////////////////////////
	// Strobe, then TX, line, RX
	//////////////////////////////////////////////////

	// Shared 16x strobe
	uart_baud_gen #(
		.BAUD_DIV (BAUD_DIV)
	) i_baud_gen (
		.clk    (clk),
		.arst_n (arst_n),
		.s_tick (s_tick)
	);

	uart_tx i_tx (
		.clk     (clk),
		.arst_n  (arst_n),
		.s_tick  (s_tick),
		.req     (tx_req),
		.txd     (txd),
		.tx_done (tx_done)
	);

	// Line leaves as txd and comes back as rxd
	uart_rx i_rx (
		.clk      (clk),
		.arst_n   (arst_n),
		.s_tick   (s_tick),
		.rxd      (rxd),
		.rx_valid (rx_valid),
		.result   (rx_res)
	);

endmodule

`default_nettype wire

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_rx
	import uart_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       s_tick,
	input  logic       rxd,
	output logic       rx_valid,
	output rx_result_t result
);

	localparam int S_W   = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);

	// Half a bit from the falling edge to the start-bit middle
	localparam logic [S_W-1:0] S_HALF = S_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [S_W-1:0] S_FULL = S_W'(`UART_OVERSAMPLE - 1);

	rx_state_e                  state;
	logic                       rxd_meta;
	logic                       rxd_sync;
	logic [S_W-1:0]             s_cnt;
	logic [BIT_W-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shreg;
	logic                       sample_data;

	//////////////////////////////////////////////////
	// Line synchronizer
	//////////////////////////////////////////////////

	// Idle line is high, so no false start out of reset
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	// Middle of a data bit
	assign sample_data = s_tick && (state == RX_DATA) && (s_cnt == S_FULL);

	// LSB arrives first, shift right
	always_ff @(posedge clk)
	begin
		if (sample_data)
			shreg <= {rxd_sync, shreg[`UART_DATA_BITS-1:1]};
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= RX_IDLE;
			s_cnt    <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
			result   <= '0;
		end
		else
		begin
			// Single-clock pulse
			rx_valid <= 1'b0;
			if (s_tick)
			begin
				case (state)
					RX_IDLE:
					begin
						// Falling edge seen, this strobe counts as 0
						if (!rxd_sync)
						begin
							s_cnt <= '0;
							state <= RX_START_CHECK;
						end
					end
					RX_START_CHECK:
					begin
						if (s_cnt == S_HALF)
						begin
							s_cnt   <= '0;
							bit_cnt <= '0;
							// Glitch if the line is back high
							state   <= rxd_sync ? RX_IDLE : RX_DATA;
						end
						else
							s_cnt <= s_cnt + 1'b1;
					end
					RX_DATA:
					begin
						if (s_cnt == S_FULL)
						begin
							s_cnt   <= '0;
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1))
								state <= RX_STOP;
						end
						else
							s_cnt <= s_cnt + 1'b1;
					end
					RX_STOP:
					begin
						if (s_cnt == S_FULL)
						begin
							s_cnt            <= '0;
							// Low stop bit is a framing error
							result.data      <= shreg;
							result.frame_err <= ~rxd_sync;
							rx_valid         <= 1'b1;
							state            <= RX_IDLE;
						end
						else
							s_cnt <= s_cnt + 1'b1;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_tx
	import uart_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    s_tick,
	input  tx_req_t req,
	output logic    txd,
	output logic    tx_done
);

	localparam int S_W   = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W = $clog2(`UART_DATA_BITS + 2);

	tx_state_e                  state;
	// Strobes already spent in the current bit
	logic [S_W-1:0]             s_cnt;
	// Bits sent so far, data then stop
	logic [BIT_W-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shreg;
	logic                       accept;
	logic                       bit_end;
	logic                       shift;

	// Request taken only on a strobe while idle
	assign accept  = s_tick && req.start && tx_done && (state == TX_IDLE);
	// Last strobe of a 16-strobe bit
	assign bit_end = s_tick && (state == TX_WAIT) && (s_cnt == S_W'(`UART_OVERSAMPLE - 1));
	// Next data bit goes out
	assign shift   = bit_end && (bit_cnt < BIT_W'(`UART_DATA_BITS));

	// Byte buffer, LSB leaves first
	always_ff @(posedge clk)
	begin
		if (accept)
			shreg <= req.data;
		else if (shift)
			shreg <= shreg >> 1;
	end

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= TX_IDLE;
			s_cnt   <= '0;
			bit_cnt <= '0;
			txd     <= 1'b1;
			tx_done <= 1'b1;
		end
		else if (s_tick)
		begin
			case (state)
				TX_IDLE:
				begin
					// Accepting strobe is strobe 0 of the start bit
					if (accept)
					begin
						txd     <= 1'b0;
						tx_done <= 1'b0;
						s_cnt   <= '0;
						bit_cnt <= '0;
						state   <= TX_START;
					end
				end
				TX_START, TX_DATA, TX_STOP:
				begin
					// First strobe after a bit edge
					s_cnt <= s_cnt + 1'b1;
					if (state != TX_START)
						bit_cnt <= bit_cnt + 1'b1;
					state <= TX_WAIT;
				end
				TX_WAIT:
				begin
					if (bit_end)
					begin
						s_cnt <= '0;
						if (shift)
						begin
							txd   <= shreg[0];
							state <= TX_DATA;
						end
						else if (bit_cnt == BIT_W'(`UART_DATA_BITS))
						begin
							// Stop bit
							txd   <= 1'b1;
							state <= TX_STOP;
						end
						else
						begin
							// Stop bit done, line stays high
							tx_done <= 1'b1;
							state   <= TX_IDLE;
						end
					end
					else
						s_cnt <= s_cnt + 1'b1;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_baud_gen.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "uart_consts.svh"

module uart_baud_gen #(
	parameter int BAUD_DIV = `UART_BAUD_DIV
) (
	input  logic clk,
	input  logic arst_n,
	output logic s_tick
);

	// Counter wide enough for BAUD_DIV-1, at least one bit
	localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(BAUD_DIV - 1);

	logic [CNT_W-1:0] cnt;

	// Wrapping down-counter
	// Strobe is registered, so first one lands BAUD_DIV clocks after reset
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt    <= CNT_LOAD;
			s_tick <= 1'b0;
		end
		else
		begin
			s_tick <= (cnt == '0);
			// Reload on zero, one strobe per BAUD_DIV clocks
			if (cnt == '0)
				cnt <= CNT_LOAD;
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none
`include "uart_consts.svh"

package uart_pkg;

	//////////////////////////////////////////////////
	// FSM states
	//////////////////////////////////////////////////

	// Transmitter FSM
	// Start, data and stop last one strobe each, wait counts out the bit
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_WAIT,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	// Receiver
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START_CHECK,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	//////////////////////////////////////////////////
	// Link payloads
	//////////////////////////////////////////////////

	// Byte request into the transmitter
	typedef struct packed {
		logic                         start;
		logic [`UART_DATA_BITS-1:0]   data;
	} tx_req_t;

	// Byte held by the receiver until the next frame
	typedef struct packed {
		logic [`UART_DATA_BITS-1:0]   data;
		logic                         frame_err;
	} rx_result_t;

endpackage

`default_nettype wire

// ==== include/uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Strobes per serial bit
`define UART_OVERSAMPLE 16

// Data bits in one 8N1 frame
`define UART_DATA_BITS 8

// Clocks per oversample strobe
// 50 MHz clock, 115200 baud, 16x oversampling
`define UART_BAUD_DIV 27

`endif
